// File: fml_pkg.sv
//------------------------------
// Shared memory link constants
// Region map and timing values
// Arbiter owner encoding
//------------------------------
package fml_pkg;

	// Link widths
	localparam int DATA_W = 64;
	localparam int SEL_W = 8;
	localparam int ADR_W = 8;
	localparam int MEM_WORDS = 256;

	// Strobe to acknowledge, acknowledge cycle included
	localparam int MEM_LATENCY = 3;
	localparam int LAT_CNT_W = $clog2(MEM_LATENCY);

	// Framebuffer region
	localparam logic [ADR_W-1:0] FB_BASE = ADR_W'(0);
	localparam int FB_WORDS = 16;
	localparam logic [ADR_W-1:0] FB_LAST = FB_BASE + ADR_W'(FB_WORDS - 1);
	localparam int FETCH_INTERVAL = 12;
	localparam int FETCH_CNT_W = $clog2(FETCH_INTERVAL);

	// Capture region
	localparam logic [ADR_W-1:0] CAP_BASE = ADR_W'(128);
	localparam int CAP_WORDS = 16;
	localparam logic [ADR_W-1:0] CAP_LAST = CAP_BASE + ADR_W'(CAP_WORDS - 1);
	localparam int SAMPLE_W = 16;
	localparam int SAMPLES_PER_WORD = 4;
	localparam int POS_W = $clog2(SAMPLES_PER_WORD);

	// Reset holds, shortened for simulation
	localparam int RST_HOLD_CYCLES = 256;
	localparam int RST_CNT_W = $clog2(RST_HOLD_CYCLES + 1);
	localparam int FLASH_RST_CYCLES = 128;
	localparam int FLASH_CNT_W = $clog2(FLASH_RST_CYCLES + 1);

	// Usage meter
	localparam int METER_W = 32;

	// Current owner of the memory link
	typedef enum logic [1:0] {
		OWN_NONE = 2'd0,
		OWN_FETCH = 2'd1,
		OWN_HOST = 2'd2,
		OWN_CAPTURE = 2'd3
	} owner_t;

endpackage

// File: reset_gen.sv
//------------------------------
// System reset debounce
// Early flash reset release
//------------------------------
`timescale 1ns/1ns

module reset_gen import fml_pkg::*; (
	input logic sys_clk,
	input logic trigger_reset,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	logic [RST_CNT_W-1:0] rst_debounce;
	logic [FLASH_CNT_W-1:0] flash_cnt;

	//------------------------------
	// System reset
	//------------------------------
	// Reloaded while trigger is high, then counts down to zero
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			rst_debounce <= RST_CNT_W'(RST_HOLD_CYCLES);
			sys_rst_o <= 1'b1;
		end else begin
			if (rst_debounce != '0)
				rst_debounce <= rst_debounce - 1'b1;
			// Registered, so release lands one cycle after the count ends
			sys_rst_o <= (rst_debounce != '0);
		end
	end

	//------------------------------
	// Flash reset
	//------------------------------
	// Shorter hold, the flash must be out of reset before the system
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			flash_cnt <= '0;
			flash_rst_n_o <= 1'b0;
		end else begin
			if (flash_cnt != FLASH_CNT_W'(FLASH_RST_CYCLES))
				flash_cnt <= flash_cnt + 1'b1;
			flash_rst_n_o <= (flash_cnt == FLASH_CNT_W'(FLASH_RST_CYCLES));
		end
	end

endmodule

// File: frame_fetch.sv
//------------------------------
// Framebuffer fetch engine
// Paced sequential word reads
//------------------------------
`timescale 1ns/1ns

module frame_fetch import fml_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic scan_en_i,
	input logic fml_ack_i,
	input logic [DATA_W-1:0] fml_dat_i,
	output logic fml_stb_o,
	output logic [ADR_W-1:0] fml_adr_o,
	output logic pix_valid_o,
	output logic [DATA_W-1:0] pix_o
);

	localparam logic [FETCH_CNT_W-1:0] PACE_LAST = FETCH_CNT_W'(FETCH_INTERVAL - 1);

	logic [FETCH_CNT_W-1:0] pace;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fml_stb_o <= 1'b0;
			fml_adr_o <= FB_BASE;
			pace <= '0;
			pix_valid_o <= 1'b0;
		end else begin
			// One pixel word per acknowledge
			pix_valid_o <= fml_stb_o & fml_ack_i;

			// Pacing, holds at the last count until the link is free
			if (!scan_en_i)
				pace <= '0;
			else if (pace != PACE_LAST)
				pace <= pace + 1'b1;
			else if (!fml_stb_o)
				pace <= '0;

			// Request and address
			if (fml_stb_o) begin
				if (fml_ack_i) begin
					fml_stb_o <= 1'b0;
					// Wrap at the end of the framebuffer
					fml_adr_o <= (fml_adr_o == FB_LAST) ? FB_BASE : fml_adr_o + 1'b1;
				end
			end else if (!scan_en_i) begin
				fml_adr_o <= FB_BASE;
			end else if (pace == PACE_LAST) begin
				fml_stb_o <= 1'b1;
			end
		end
	end

	// Pixel word register
	always_ff @(posedge sys_clk) begin
		if (fml_stb_o && fml_ack_i)
			pix_o <= fml_dat_i;
	end

endmodule

// File: capture_writer.sv
//------------------------------
// Video capture writer
// Packs samples into link words
//------------------------------
`timescale 1ns/1ns

module capture_writer import fml_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic cap_en_i,
	input logic vid_valid_i,
	input logic [SAMPLE_W-1:0] vid_dat_i,
	input logic fml_ack_i,
	output logic fml_stb_o,
	output logic [ADR_W-1:0] fml_adr_o,
	output logic [DATA_W-1:0] fml_dat_o
);

	localparam logic [POS_W-1:0] POS_LAST = POS_W'(SAMPLES_PER_WORD - 1);

	logic [DATA_W-1:0] pack;
	logic [DATA_W-1:0] word_next;
	logic [POS_W-1:0] pos;
	logic full_q;
	logic take;
	logic word_done;
	logic load;

	// New sample enters at the top, first sample ends up lowest
	assign word_next = {vid_dat_i, pack[DATA_W-1:SAMPLE_W]};
	assign take = cap_en_i & vid_valid_i;
	assign word_done = take & (pos == POS_LAST);
	// Hand a finished word to the pending register once it is free
	assign load = cap_en_i & (word_done | full_q) & (~fml_stb_o | fml_ack_i);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pos <= '0;
			full_q <= 1'b0;
			fml_stb_o <= 1'b0;
			fml_adr_o <= CAP_BASE;
		end else begin
			if (take)
				pos <= (pos == POS_LAST) ? '0 : pos + 1'b1;
			if (fml_stb_o && fml_ack_i) begin
				fml_stb_o <= 1'b0;
				fml_adr_o <= (fml_adr_o == CAP_LAST) ? CAP_BASE : fml_adr_o + 1'b1;
			end
			// New request may start in the cycle after the acknowledge
			if (load) begin
				fml_stb_o <= 1'b1;
				full_q <= 1'b0;
			end else if (word_done) begin
				full_q <= 1'b1;
			end
			// Back to the start, a running write still completes
			if (!cap_en_i) begin
				pos <= '0;
				full_q <= 1'b0;
				if (!fml_stb_o)
					fml_adr_o <= CAP_BASE;
			end
		end
	end

	// Staging and pending words
	always_ff @(posedge sys_clk) begin
		if (take)
			pack <= word_next;
		if (load)
			fml_dat_o <= full_q ? pack : word_next;
	end

endmodule

// File: fml_arbiter.sv
//------------------------------
// Fixed-priority link arbiter
// Fetch, then host, then capture
//------------------------------
`timescale 1ns/1ns

module fml_arbiter import fml_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,

	// Master 0, framebuffer fetch
	input logic m0_stb_i,
	input logic [ADR_W-1:0] m0_adr_i,
	output logic m0_ack_o,
	output logic [DATA_W-1:0] m0_dat_o,

	// Master 1, host port
	input logic m1_stb_i,
	input logic m1_we_i,
	input logic [ADR_W-1:0] m1_adr_i,
	input logic [SEL_W-1:0] m1_sel_i,
	input logic [DATA_W-1:0] m1_dat_i,
	output logic m1_ack_o,
	output logic [DATA_W-1:0] m1_dat_o,

	// Master 2, capture writer
	input logic m2_stb_i,
	input logic [ADR_W-1:0] m2_adr_i,
	input logic [DATA_W-1:0] m2_dat_i,
	output logic m2_ack_o,

	// Memory side
	output logic s_stb_o,
	output logic s_we_o,
	output logic [ADR_W-1:0] s_adr_o,
	output logic [SEL_W-1:0] s_sel_o,
	output logic [DATA_W-1:0] s_dat_o,
	input logic s_ack_i,
	input logic [DATA_W-1:0] s_dat_i
);

	owner_t owner;

	// Grant only from idle, hold until the memory acknowledges
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			owner <= OWN_NONE;
		end else if (owner == OWN_NONE) begin
			if (m0_stb_i)
				owner <= OWN_FETCH;
			else if (m1_stb_i)
				owner <= OWN_HOST;
			else if (m2_stb_i)
				owner <= OWN_CAPTURE;
		end else if (s_ack_i) begin
			owner <= OWN_NONE;
		end
	end

	//------------------------------
	// Request mux
	//------------------------------
	always_comb begin
		s_stb_o = 1'b0;
		s_we_o = 1'b0;
		s_adr_o = '0;
		s_sel_o = '1;
		s_dat_o = '0;
		case (owner)
			OWN_FETCH: begin
				s_stb_o = m0_stb_i;
				s_adr_o = m0_adr_i;
			end
			OWN_HOST: begin
				s_stb_o = m1_stb_i;
				s_we_o = m1_we_i;
				s_adr_o = m1_adr_i;
				s_sel_o = m1_sel_i;
				s_dat_o = m1_dat_i;
			end
			OWN_CAPTURE: begin
				// Capture always writes whole words
				s_stb_o = m2_stb_i;
				s_we_o = 1'b1;
				s_adr_o = m2_adr_i;
				s_dat_o = m2_dat_i;
			end
			default: ;
		endcase
	end

	// Return path, acknowledge only to the owner
	assign m0_ack_o = s_ack_i & (owner == OWN_FETCH);
	assign m1_ack_o = s_ack_i & (owner == OWN_HOST);
	assign m2_ack_o = s_ack_i & (owner == OWN_CAPTURE);
	assign m0_dat_o = s_dat_i;
	assign m1_dat_o = s_dat_i;

endmodule

// File: word_memory.sv
//------------------------------
// Fixed-latency word memory
// Byte-select writes
//------------------------------
`timescale 1ns/1ns

module word_memory import fml_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic stb_i,
	input logic we_i,
	input logic [ADR_W-1:0] adr_i,
	input logic [SEL_W-1:0] sel_i,
	input logic [DATA_W-1:0] dat_i,
	output logic ack_o,
	output logic [DATA_W-1:0] dat_o
);

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [LAT_CNT_W-1:0] lat_cnt;
	logic ack_next;

	// Acknowledge follows in the last strobe cycle
	assign ack_next = stb_i & ~ack_o & (lat_cnt == LAT_CNT_W'(MEM_LATENCY - 2));

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || !stb_i || ack_o) begin
			lat_cnt <= '0;
			ack_o <= 1'b0;
		end else begin
			lat_cnt <= lat_cnt + 1'b1;
			ack_o <= ack_next;
		end
	end

	// Read word lines up with the acknowledge, write lands in the ack cycle
	always_ff @(posedge sys_clk) begin
		if (ack_next)
			dat_o <= mem[adr_i];
		if (ack_o && we_i) begin
			for (int b = 0; b < SEL_W; b++)
				if (sel_i[b])
					mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
		end
	end

endmodule

// File: usage_meter.sv
//------------------------------
// Link usage meter
//------------------------------
`timescale 1ns/1ns

module usage_meter import fml_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic clr_i,
	input logic stb_i,
	input logic ack_i,
	output logic [METER_W-1:0] stb_count_o,
	output logic [METER_W-1:0] ack_count_o
);

	// Both counters stick at all ones
	always_ff @(posedge sys_clk) begin
		if (sys_rst || clr_i) begin
			stb_count_o <= '0;
			ack_count_o <= '0;
		end else begin
			// Busy cycles
			if (stb_i && stb_count_o != '1)
				stb_count_o <= stb_count_o + 1'b1;
			// Completed transfers
			if (ack_i && ack_count_o != '1)
				ack_count_o <= ack_count_o + 1'b1;
		end
	end

endmodule

// File: fml_system.sv
//------------------------------
// Shared memory system top
// Peers, arbiter, memory, meter
//------------------------------
`timescale 1ns/1ns

module fml_system import fml_pkg::*; (
	input logic sys_clk,
	input logic trigger_reset,

	// Host port
	input logic host_stb_i,
	input logic host_we_i,
	input logic [ADR_W-1:0] host_adr_i,
	input logic [SEL_W-1:0] host_sel_i,
	input logic [DATA_W-1:0] host_dat_i,
	output logic host_ack_o,
	output logic [DATA_W-1:0] host_dat_o,

	// Framebuffer scan
	input logic scan_en_i,
	output logic pix_valid_o,
	output logic [DATA_W-1:0] pix_o,

	// Video capture
	input logic cap_en_i,
	input logic vid_valid_i,
	input logic [SAMPLE_W-1:0] vid_dat_i,

	// Meter
	input logic meter_clr_i,
	output logic [METER_W-1:0] stb_count_o,
	output logic [METER_W-1:0] ack_count_o,

	output logic ready_o,
	output logic flash_rst_n_o
);

	logic sys_rst;

	// Fetch master
	logic fetch_stb, fetch_ack;
	logic [ADR_W-1:0] fetch_adr;
	logic [DATA_W-1:0] fetch_dat;

	// Capture master
	logic cap_stb, cap_ack;
	logic [ADR_W-1:0] cap_adr;
	logic [DATA_W-1:0] cap_dat;

	// Memory link
	logic fml_stb, fml_we, fml_ack;
	logic [ADR_W-1:0] fml_adr;
	logic [SEL_W-1:0] fml_sel;
	logic [DATA_W-1:0] fml_dw, fml_dr;

	reset_gen reset_gen_i (
		.sys_clk(sys_clk), .trigger_reset(trigger_reset),
		.sys_rst_o(sys_rst), .flash_rst_n_o(flash_rst_n_o)
	);

	assign ready_o = ~sys_rst;

	frame_fetch frame_fetch_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .scan_en_i(scan_en_i),
		.fml_ack_i(fetch_ack), .fml_dat_i(fetch_dat),
		.fml_stb_o(fetch_stb), .fml_adr_o(fetch_adr),
		.pix_valid_o(pix_valid_o), .pix_o(pix_o)
	);

	capture_writer capture_writer_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .cap_en_i(cap_en_i),
		.vid_valid_i(vid_valid_i), .vid_dat_i(vid_dat_i), .fml_ack_i(cap_ack),
		.fml_stb_o(cap_stb), .fml_adr_o(cap_adr), .fml_dat_o(cap_dat)
	);

	// Fetch has top priority, like the display master
	fml_arbiter fml_arbiter_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.m0_stb_i(fetch_stb), .m0_adr_i(fetch_adr),
		.m0_ack_o(fetch_ack), .m0_dat_o(fetch_dat),
		.m1_stb_i(host_stb_i), .m1_we_i(host_we_i), .m1_adr_i(host_adr_i),
		.m1_sel_i(host_sel_i), .m1_dat_i(host_dat_i),
		.m1_ack_o(host_ack_o), .m1_dat_o(host_dat_o),
		.m2_stb_i(cap_stb), .m2_adr_i(cap_adr), .m2_dat_i(cap_dat),
		.m2_ack_o(cap_ack),
		.s_stb_o(fml_stb), .s_we_o(fml_we), .s_adr_o(fml_adr),
		.s_sel_o(fml_sel), .s_dat_o(fml_dw),
		.s_ack_i(fml_ack), .s_dat_i(fml_dr)
	);

	word_memory word_memory_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .stb_i(fml_stb), .we_i(fml_we),
		.adr_i(fml_adr), .sel_i(fml_sel), .dat_i(fml_dw),
		.ack_o(fml_ack), .dat_o(fml_dr)
	);

	usage_meter usage_meter_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .clr_i(meter_clr_i),
		.stb_i(fml_stb), .ack_i(fml_ack),
		.stb_count_o(stb_count_o), .ack_count_o(ack_count_o)
	);

endmodule

// File: fml_assert.sv
//------------------------------
// Arbiter link assertions
// Bound into the arbiter
//------------------------------
`timescale 1ns/1ns

module fml_assert import fml_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input owner_t owner,
	input logic s_stb_o,
	input logic s_we_o,
	input logic [ADR_W-1:0] s_adr_o,
	input logic [SEL_W-1:0] s_sel_o,
	input logic [DATA_W-1:0] s_dat_o,
	input logic s_ack_i
);

	// Link strobe high exactly while an owner holds the grant
	stb_owned: assert property (@(posedge sys_clk) disable iff (sys_rst)
		s_stb_o == (owner != OWN_NONE))
		else $error("memory strobe does not follow the arbiter owner");

	// Request held steady until the acknowledge
	req_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(s_stb_o && !s_ack_i) |=> s_stb_o && $stable(s_we_o) && $stable(s_adr_o)
			&& $stable(s_sel_o) && $stable(s_dat_o))
		else $error("memory request changed before its acknowledge");

	// No acknowledge on an idle link
	ack_with_stb: assert property (@(posedge sys_clk) disable iff (sys_rst)
		s_ack_i |-> s_stb_o)
		else $error("memory acknowledge without a strobe");

endmodule

bind fml_arbiter fml_assert fml_assert_i (
	.sys_clk(sys_clk), .sys_rst(sys_rst), .owner(owner),
	.s_stb_o(s_stb_o), .s_we_o(s_we_o), .s_adr_o(s_adr_o),
	.s_sel_o(s_sel_o), .s_dat_o(s_dat_o), .s_ack_i(s_ack_i)
);

// File: tb_fml_system.sv
//------------------------------
// Testbench for the shared memory system
// Host table, capture and scan checks
// Shadow memory model, watchdog
//------------------------------
`timescale 1ns/1ns

module tb_fml_system import fml_pkg::*; ();

	// Host scratch region, away from framebuffer and capture
	localparam logic [ADR_W-1:0] HOST_BASE = ADR_W'(64);
	localparam int HOST_WORDS = 16;
	localparam int NUM_OPS = FB_WORDS + 24;
	localparam int NUM_SAMPLES = SAMPLES_PER_WORD * CAP_WORDS + 8;
	localparam int CAP_WRITES = NUM_SAMPLES / SAMPLES_PER_WORD;
	// Enough pixels to see the framebuffer wrap
	localparam int PIX_TARGET = FB_WORDS + 4;
	localparam int WATCHDOG_CYCLES = (NUM_OPS + CAP_WORDS + HOST_WORDS) * 40
		+ RST_HOLD_CYCLES + 16 + 2 * NUM_SAMPLES + 2 * PIX_TARGET * FETCH_INTERVAL;

	logic sys_clk = 1'b0;
	logic trigger_reset;
	logic host_stb_i;
	logic host_we_i;
	logic [ADR_W-1:0] host_adr_i;
	logic [SEL_W-1:0] host_sel_i;
	logic [DATA_W-1:0] host_dat_i;
	logic host_ack_o;
	logic [DATA_W-1:0] host_dat_o;
	logic scan_en_i;
	logic pix_valid_o;
	logic [DATA_W-1:0] pix_o;
	logic cap_en_i;
	logic vid_valid_i;
	logic [SAMPLE_W-1:0] vid_dat_i;
	logic meter_clr_i;
	logic [METER_W-1:0] stb_count_o;
	logic [METER_W-1:0] ack_count_o;
	logic ready_o;
	logic flash_rst_n_o;

	//------------------------------
	// Stimulus table and shadow memory
	//------------------------------
	logic op_we [NUM_OPS];
	logic [ADR_W-1:0] op_adr [NUM_OPS];
	logic [SEL_W-1:0] op_sel [NUM_OPS];
	logic [DATA_W-1:0] op_dat [NUM_OPS];
	// Expected read data, taken from the shadow before the op
	logic [DATA_W-1:0] op_exp [NUM_OPS];
	logic [SAMPLE_W-1:0] samples [NUM_SAMPLES];
	logic [DATA_W-1:0] shadow [MEM_WORDS];
	int errors = 0;
	int pix_count = 0;

	fml_system fml_system_i (
		.sys_clk(sys_clk), .trigger_reset(trigger_reset),
		.host_stb_i(host_stb_i), .host_we_i(host_we_i), .host_adr_i(host_adr_i),
		.host_sel_i(host_sel_i), .host_dat_i(host_dat_i),
		.host_ack_o(host_ack_o), .host_dat_o(host_dat_o),
		.scan_en_i(scan_en_i), .pix_valid_o(pix_valid_o), .pix_o(pix_o),
		.cap_en_i(cap_en_i), .vid_valid_i(vid_valid_i), .vid_dat_i(vid_dat_i),
		.meter_clr_i(meter_clr_i), .stb_count_o(stb_count_o), .ack_count_o(ack_count_o),
		.ready_o(ready_o), .flash_rst_n_o(flash_rst_n_o)
	);

	// 100 ns period
	always #50 sys_clk = ~sys_clk;

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp_val,
			input logic [DATA_W-1:0] act_val);
		errors++;
		$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
	endtask

	// Merge only the selected bytes
	task automatic shadow_write(input logic [ADR_W-1:0] adr, input logic [SEL_W-1:0] sel,
			input logic [DATA_W-1:0] dat);
		for (int b = 0; b < SEL_W; b++)
			if (sel[b])
				shadow[adr][8*b +: 8] = dat[8*b +: 8];
	endtask

	task automatic build_table();
		for (int a = 0; a < MEM_WORDS; a++)
			shadow[a] = '0;
		for (int i = 0; i < NUM_OPS; i++) begin
			if (i < FB_WORDS) begin
				// Framebuffer fill, whole words
				op_we[i] = 1'b1;
				op_adr[i] = FB_BASE + ADR_W'(i);
				op_sel[i] = '1;
			end else begin
				// First random op reads an unwritten word
				op_we[i] = (i != FB_WORDS) && ($urandom % 2 == 1);
				op_adr[i] = HOST_BASE + ADR_W'($urandom % HOST_WORDS);
				op_sel[i] = SEL_W'($urandom);
			end
			op_dat[i] = {$urandom, $urandom};
			op_exp[i] = shadow[op_adr[i]];
			if (op_we[i])
				shadow_write(op_adr[i], op_sel[i], op_dat[i]);
		end
		for (int s = 0; s < NUM_SAMPLES; s++)
			samples[s] = SAMPLE_W'($urandom);
	endtask

	// One host transfer, entered and left on a falling edge
	task automatic host_op(input logic we, input logic [ADR_W-1:0] adr,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] dat,
			output logic [DATA_W-1:0] rdat);
		host_stb_i = 1'b1;
		host_we_i = we;
		host_adr_i = adr;
		host_sel_i = sel;
		host_dat_i = dat;
		@(negedge sys_clk);
		while (host_ack_o !== 1'b1)
			@(negedge sys_clk);
		rdat = host_dat_o;
		// Fields held through the acknowledge cycle
		@(negedge sys_clk);
		host_stb_i = 1'b0;
	endtask

	// Pixel words in address order, wrapping at the region end
	always @(negedge sys_clk) begin
		if (pix_valid_o === 1'b1) begin
			if (pix_o !== shadow[ADR_W'(FB_BASE + pix_count % FB_WORDS)])
				report_mismatch($sformatf("pixel %0d", pix_count),
					shadow[ADR_W'(FB_BASE + pix_count % FB_WORDS)], pix_o);
			pix_count++;
		end
	end

	initial begin
		logic [DATA_W-1:0] rd;
		logic [DATA_W-1:0] exp_word;
		int flash_rise;
		int ready_rise;
		int w;

		trigger_reset = 1'b1;
		host_stb_i = 1'b0;
		host_we_i = 1'b0;
		host_adr_i = '0;
		host_sel_i = '0;
		host_dat_i = '0;
		scan_en_i = 1'b0;
		cap_en_i = 1'b0;
		vid_valid_i = 1'b0;
		vid_dat_i = '0;
		meter_clr_i = 1'b0;
		void'($urandom(54));
		build_table();

		//------------------------------
		// Reset release
		//------------------------------
		repeat (8) @(negedge sys_clk);
		if (flash_rst_n_o !== 1'b0 || ready_o !== 1'b0) begin
			errors++;
			$display("Flash reset or ready released while trigger_reset is high");
		end
		trigger_reset = 1'b0;
		flash_rise = -1;
		ready_rise = -1;
		// Count c is the rising edge that sampled the trigger low, plus c
		for (int c = 0; c <= RST_HOLD_CYCLES + 1; c++) begin
			@(negedge sys_clk);
			if (flash_rise < 0 && flash_rst_n_o === 1'b1)
				flash_rise = c;
			if (ready_rise < 0 && ready_o === 1'b1)
				ready_rise = c;
		end
		if (flash_rise != FLASH_RST_CYCLES)
			report_mismatch("flash reset release", DATA_W'(FLASH_RST_CYCLES),
				DATA_W'(flash_rise));
		if (ready_rise != RST_HOLD_CYCLES)
			report_mismatch("system ready", DATA_W'(RST_HOLD_CYCLES), DATA_W'(ready_rise));

		// Framebuffer fill, then byte-select writes and reads
		for (int i = 0; i < NUM_OPS; i++) begin
			host_op(op_we[i], op_adr[i], op_sel[i], op_dat[i], rd);
			if (!op_we[i] && rd !== op_exp[i])
				report_mismatch($sformatf("host op %0d", i), op_exp[i], rd);
		end

		//------------------------------
		// Capture packing
		//------------------------------
		cap_en_i = 1'b1;
		@(negedge sys_clk);
		// One sample every other cycle keeps word writes well apart
		for (int s = 0; s < NUM_SAMPLES; s++) begin
			vid_valid_i = 1'b1;
			vid_dat_i = samples[s];
			@(negedge sys_clk);
			vid_valid_i = 1'b0;
			@(negedge sys_clk);
		end
		// Last word: grant, strobe cycles, idle
		repeat (MEM_LATENCY + 2) @(negedge sys_clk);
		cap_en_i = 1'b0;
		for (int k = 0; k < CAP_WORDS; k++) begin
			// Words past the wrap land at the start of the region
			w = (k + CAP_WORDS < CAP_WRITES) ? k + CAP_WORDS : k;
			for (int j = 0; j < SAMPLES_PER_WORD; j++)
				exp_word[SAMPLE_W*j +: SAMPLE_W] = samples[SAMPLES_PER_WORD*w + j];
			host_op(1'b0, CAP_BASE + ADR_W'(k), '1, '0, rd);
			if (rd !== exp_word)
				report_mismatch($sformatf("capture word %0d", k), exp_word, rd);
		end

		//------------------------------
		// Scan with host traffic, meter
		//------------------------------
		scan_en_i = 1'b1;
		meter_clr_i = 1'b1;
		@(negedge sys_clk);
		meter_clr_i = 1'b0;
		for (int k = 0; k < HOST_WORDS; k++) begin
			host_op(1'b0, HOST_BASE + ADR_W'(k), '1, '0, rd);
			if (rd !== shadow[HOST_BASE + ADR_W'(k)])
				report_mismatch($sformatf("shared read %0d", k),
					shadow[HOST_BASE + ADR_W'(k)], rd);
		end
		while (pix_count < PIX_TARGET)
			@(negedge sys_clk);
		scan_en_i = 1'b0;
		// A fetch already on the link still completes
		repeat (2 * (MEM_LATENCY + 2)) @(negedge sys_clk);
		if (ack_count_o !== METER_W'(HOST_WORDS + pix_count))
			report_mismatch("meter acknowledges", DATA_W'(HOST_WORDS + pix_count),
				DATA_W'(ack_count_o));
		if (stb_count_o !== METER_W'((HOST_WORDS + pix_count) * MEM_LATENCY))
			report_mismatch("meter strobe cycles",
				DATA_W'((HOST_WORDS + pix_count) * MEM_LATENCY), DATA_W'(stb_count_o));

		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("Timeout after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: tb.f
fml_pkg.sv
reset_gen.sv
frame_fetch.sv
capture_writer.sv
fml_arbiter.sv
word_memory.sv
usage_meter.sv
fml_system.sv
fml_assert.sv
tb_fml_system.sv

// File: run.sh
#!/bin/sh
# Compile and run the shared memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_fml_system -f tb.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! out=$(./obj_dir/Vtb_fml_system); then
	printf '%s\n' "$out"
	echo "Simulation exited with an error"
	exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
